//--- dv/tb_bus_target.sv
/* Behavioral bus target: 1024-word memory, random grant delay,
   busy and read gaps, and error injection at a chosen word */

`timescale 1ns/1ps

module tb_bus_target (
    input  logic               clock,
    input  logic               clear_count,
    input  int                 err_word,
    input  dma_pkg::bus_m2s_t  bus_out,
    output dma_pkg::bus_s2m_t  bus_in
);
    import dma_pkg::*;

    typedef enum {ph_idle, ph_wait, ph_granted, ph_read, ph_write} phase_e;

    logic [31:0] mem [1024];
    logic [31:0] lfsr;
    phase_e      phase = ph_idle;
    int          wait_cnt;
    int          word_idx;
    int          words_left;
    logic [9:0]  word_addr;
    logic [1:0]  rnd;
    bus_s2m_t    drive_q = '0;

    assign bus_in = drive_q;

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial begin : fill
        logic [31:0] s;
        logic [31:0] w;
        s = 32'h15db_a76b;
        for (int a = 0; a < 1024; a++) begin
            for (int b = 0; b < 32; b++) begin
                s    = lfsr_step(s);
                w[b] = s[0];
            end
            mem[a] = w;
        end
        lfsr = s;
    end

    // Falling edge model so the engine samples responses at the next rising edge
    always @(negedge clock) begin
        drive_q <= '0;
        if (clear_count) begin
            word_idx <= 0;
        end
        if (bus_out.begin_transaction) begin
            word_addr  <= bus_out.address_data[11:2];
            words_left <= int'(bus_out.burst_size) + 1;
            phase      <= bus_out.read_n_write ? ph_read : ph_write;
        end else begin
            case (phase)
                ph_idle: begin
                    if (bus_out.request) begin
                        lfsr     = lfsr_step(lfsr);
                        rnd[0]   = lfsr[0];
                        lfsr     = lfsr_step(lfsr);
                        rnd[1]   = lfsr[0];
                        // Grant 1 to 3 cycles later
                        wait_cnt <= int'(rnd) % 3;
                        phase    <= ph_wait;
                    end
                end
                ph_wait: begin
                    if (wait_cnt == 0) begin
                        drive_q.grant <= 1'b1;
                        phase         <= ph_granted;
                    end else begin
                        wait_cnt <= wait_cnt - 1;
                    end
                end
                ph_read: begin
                    lfsr   = lfsr_step(lfsr);
                    rnd[0] = lfsr[0];
                    lfsr   = lfsr_step(lfsr);
                    rnd[1] = lfsr[0];
                    // Gap in one cycle of four
                    if (rnd != 2'b11) begin
                        if (word_idx == err_word) begin
                            drive_q.error <= 1'b1;
                            phase         <= ph_idle;
                        end else begin
                            drive_q.data_valid   <= 1'b1;
                            drive_q.address_data <= mem[word_addr];
                            word_addr  <= word_addr + 1'b1;
                            word_idx   <= word_idx + 1;
                            words_left <= words_left - 1;
                            if (words_left == 1) begin
                                drive_q.end_transaction <= 1'b1;
                                phase <= ph_idle;
                            end
                        end
                    end
                end
                ph_write: begin
                    if (bus_out.end_transaction) begin
                        phase <= ph_idle;
                    end else if (bus_out.data_valid) begin
                        if (word_idx == err_word) begin
                            drive_q.error <= 1'b1;
                            phase         <= ph_idle;
                        end else begin
                            lfsr = lfsr_step(lfsr);
                            if (lfsr[0]) begin
                                drive_q.busy <= 1'b1;
                            end else begin
                                mem[word_addr] = bus_out.address_data;
                                word_addr <= word_addr + 1'b1;
                                word_idx  <= word_idx + 1;
                            end
                        end
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- dv/tb_dma_controller.sv
/* Testbench for the DMA controller: register checks, transfer table
   with bus target model, burst monitor, watchdog and report */

`timescale 1ns/1ps

module tb_dma_controller;
    import dma_pkg::*;

    typedef struct {
        int          dir;
        logic [31:0] bus_addr;
        int          mem_start;
        int          block;
        int          burst;
        int          err_idx;
        int          bursts;
    } row_t;

    localparam int n_rows = 7;

    // dir, bus address, buffer address, block, burst field, error word, bursts
    row_t rows [n_rows] = '{
        '{0, 32'h0000_0100, 16,  40, 7,   -1, 5},
        '{0, 32'h0000_0800, 496, 37, 15,  -1, 3},
        '{1, 32'h0000_0a00, 128, 50, 9,   -1, 5},
        '{1, 32'h0000_0400, 506, 20, 0,   -1, 20},
        '{0, 32'h0000_0200, 256, 24, 7,   5,  1},
        '{1, 32'h0000_0600, 0,   30, 3,   12, 4},
        '{0, 32'h0000_0300, 384, 16, 255, -1, 1}
    };

    logic            clock;
    logic            rst_n;
    logic            cfg_valid;
    cfg_req_t        cfg_req;
    logic            cfg_ready;
    logic [31:0]     cfg_rdata;
    logic [8:0]      mem_addr;
    logic            mem_we;
    logic [31:0]     mem_wdata;
    logic [31:0]     mem_rdata;
    bus_m2s_t        bus_out;
    bus_s2m_t        bus_in;
    logic            clear_count;
    int              err_word;
    int              test_errors;
    int              failed_tests;
    int              begin_count;
    int              begin_sizes [256];

    dma_controller i_dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_req   (cfg_req),
        .cfg_ready (cfg_ready),
        .cfg_rdata (cfg_rdata),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .bus_out   (bus_out),
        .bus_in    (bus_in)
    );

    tb_bus_target i_target (
        .clock       (clock),
        .clear_count (clear_count),
        .err_word    (err_word),
        .bus_out     (bus_out),
        .bus_in      (bus_in)
    );

    initial clock = 1'b0;
    always #50 clock = ~clock;

    // Burst monitor recording the size field of each begin pulse
    always @(negedge clock) begin
        if (clear_count) begin
            begin_count = 0;
        end else if (bus_out.begin_transaction) begin
            begin_sizes[begin_count] = int'(bus_out.burst_size);
            begin_count = begin_count + 1;
        end
    end

    initial begin : watchdog
        int limit;
        limit = 16;
        foreach (rows[r]) begin
            limit += (rows[r].block + 4 * rows[r].bursts) * 8;
        end
        repeat (limit) @(posedge clock);
        $display("Timeout after %0d cycles, a transfer did not complete", limit);
        $display("TB FAILED");
        $finish;
    end

    function automatic logic [31:0] buf_pattern(input int test, input int addr);
        return {8'h5a, 8'(test), 7'd0, 9'(addr)};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic cfg_write(input cfg_sel_e sel, input logic [31:0] data);
        @(negedge clock);
        cfg_req   = '{sel: sel, write: 1'b1, data: data};
        cfg_valid = 1'b1;
        @(negedge clock);
        cfg_valid     = 1'b0;
        cfg_req.write = 1'b0;
    endtask

    task automatic cfg_read(input cfg_sel_e sel, output logic [31:0] data);
        @(negedge clock);
        cfg_valid     = 1'b0;
        cfg_req.write = 1'b0;
        cfg_req.sel   = sel;
        #20;
        data = cfg_rdata;
    endtask

    task automatic buf_write(input int addr, input logic [31:0] data);
        @(negedge clock);
        mem_addr  = 9'(addr);
        mem_wdata = data;
        mem_we    = 1'b1;
        @(negedge clock);
        mem_we = 1'b0;
    endtask

    task automatic buf_read(input int addr, output logic [31:0] data);
        @(negedge clock);
        mem_addr = 9'(addr);
        mem_we   = 1'b0;
        @(negedge clock);
        data = mem_rdata;
    endtask

    // Poll busy until it falls while the config port stays closed
    task automatic wait_idle();
        logic [31:0] st;
        st = 32'h4;
        while (st[2]) begin
            cfg_read(sel_ctrl_status, st);
            if (st[2]) begin
                check_eq("cfg_ready", 32'(cfg_ready), 32'd0);
            end
        end
    endtask

    task automatic report(input int test);
        if (test_errors != 0) begin
            failed_tests++;
        end
        $display("test %0d %s, %0d errors", test, (test_errors == 0) ? "ok" : "bad",
                 test_errors);
    endtask

    task automatic register_test();
        logic [31:0] v;
        test_errors = 0;
        check_eq("request", 32'(bus_out.request), 32'd0);
        check_eq("begin_transaction", 32'(bus_out.begin_transaction), 32'd0);
        check_eq("end_transaction", 32'(bus_out.end_transaction), 32'd0);
        check_eq("data_valid", 32'(bus_out.data_valid), 32'd0);
        check_eq("busy", 32'(bus_out.busy), 32'd0);
        check_eq("error", 32'(bus_out.error), 32'd0);
        check_eq("cfg_ready", 32'(cfg_ready), 32'd1);
        cfg_read(sel_ctrl_status, v);
        check_eq("status", v, 32'd0);
        cfg_read(sel_block_size, v);
        check_eq("block_size", v, 32'd0);
        cfg_write(sel_bus_start_addr, 32'hdead_beef);
        cfg_write(sel_mem_start_addr, 32'hffff_fe37);
        cfg_write(sel_block_size, 32'h1234_5abc);
        cfg_write(sel_burst_size, 32'ha5a5_a5c3);
        cfg_write(sel_ctrl_status, 32'hffff_fffc);
        cfg_read(sel_bus_start_addr, v);
        check_eq("bus_start_addr", v, 32'hdead_beef);
        cfg_read(sel_mem_start_addr, v);
        check_eq("mem_start_addr", v, 32'hffff_fe37 & 32'h1ff);
        cfg_read(sel_block_size, v);
        check_eq("block_size", v, 32'h1234_5abc & 32'h3ff);
        cfg_read(sel_burst_size, v);
        check_eq("burst_size", v, 32'ha5a5_a5c3 & 32'hff);
        cfg_read(sel_ctrl_status, v);
        check_eq("ctrl_status", v, 32'd0);
        report(0);
    endtask

    task automatic run_row(input int r);
        logic [31:0] st;
        logic [31:0] got;
        int          n_check;
        int          rem;
        int          exp_len;
        int          bw;
        int          buf_idx;
        int          tgt_idx;
        test_errors = 0;
        @(negedge clock);
        clear_count = 1'b1;
        err_word    = rows[r].err_idx;
        @(negedge clock);
        @(negedge clock);
        clear_count = 1'b0;
        if (rows[r].dir == 1) begin
            for (int i = 0; i < rows[r].block; i++) begin
                buf_idx = (rows[r].mem_start + i) % mem_depth;
                buf_write(buf_idx, buf_pattern(r, buf_idx));
            end
        end
        cfg_write(sel_bus_start_addr, rows[r].bus_addr);
        cfg_write(sel_mem_start_addr, 32'(rows[r].mem_start));
        cfg_write(sel_block_size, 32'(rows[r].block));
        cfg_write(sel_burst_size, 32'(rows[r].burst));
        cfg_write(sel_ctrl_status, (rows[r].dir == 1) ? 32'd2 : 32'd1);
        wait_idle();
        cfg_read(sel_ctrl_status, st);
        check_eq("status_error", 32'(st[3]), (rows[r].err_idx >= 0) ? 32'd1 : 32'd0);
        check_eq("ctrl_bits", 32'(st[1:0]), 32'd0);
        check_eq("begin_count", 32'(begin_count), 32'(rows[r].bursts));
        rem = rows[r].block;
        bw  = rows[r].burst + 1;
        for (int k = 0; k < begin_count && k < 256; k++) begin
            exp_len = (rem < bw) ? rem : bw;
            check_eq("burst_size", 32'(begin_sizes[k]), 32'(exp_len - 1));
            rem -= exp_len;
        end
        // Only words before an injected error are expected to arrive
        n_check = (rows[r].err_idx < 0) ? rows[r].block : rows[r].err_idx;
        for (int i = 0; i < n_check; i++) begin
            buf_idx = (rows[r].mem_start + i) % mem_depth;
            tgt_idx = (int'(rows[r].bus_addr >> 2) + i) % 1024;
            if (rows[r].dir == 0) begin
                buf_read(buf_idx, got);
                check_eq("mem_rdata", got, i_target.mem[tgt_idx]);
            end else begin
                check_eq("target_mem", i_target.mem[tgt_idx], buf_pattern(r, buf_idx));
            end
        end
        report(r + 1);
    endtask

    initial begin
        cfg_valid    = 1'b0;
        cfg_req      = '0;
        mem_addr     = '0;
        mem_we       = 1'b0;
        mem_wdata    = '0;
        clear_count  = 1'b0;
        err_word     = -1;
        failed_tests = 0;
        rst_n        = 1'b0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        register_test();
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        $display("tests %0d, passed %0d, failed %0d", n_rows + 1,
                 n_rows + 1 - failed_tests, failed_tests);
        if (failed_tests == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
source/dma_pkg.sv
source/dma_regs.sv
source/dma_buffer_mem.sv
source/dma_transfer_engine.sv
source/dma_controller.sv
dv/tb_bus_target.sv
dv/tb_dma_controller.sv

//--- run.sh
#!/bin/sh
# Build and run the DMA controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dma_controller \
    -f flist.f \
    -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TB PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

//--- source/dma_buffer_mem.sv
/* Dual-port local buffer, processor port A and engine port B */

`timescale 1ns/1ps

module dma_buffer_mem (
    input  logic                           clock,
    input  logic [dma_pkg::mem_addr_w-1:0] a_addr,
    input  logic                           a_we,
    input  logic [31:0]                    a_wdata,
    output logic [31:0]                    a_rdata,
    input  logic [dma_pkg::mem_addr_w-1:0] b_addr,
    input  logic                           b_we,
    input  logic [31:0]                    b_wdata,
    output logic [31:0]                    b_rdata
);
    import dma_pkg::*;

    logic [31:0] mem [mem_depth];

    // Both ports share one process with registered read data on each side
    always_ff @(posedge clock) begin
        if (a_we) begin
            mem[a_addr] <= a_wdata;
        end
        if (b_we) begin
            mem[b_addr] <= b_wdata;
        end
        a_rdata <= mem[a_addr];
        b_rdata <= mem[b_addr];
    end

endmodule

//--- source/dma_controller.sv
/* DMA controller top: register file, local buffer and transfer engine */

`timescale 1ns/1ps

module dma_controller (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic                           cfg_valid,
    input  dma_pkg::cfg_req_t              cfg_req,
    output logic                           cfg_ready,
    output logic [31:0]                    cfg_rdata,
    input  logic [dma_pkg::mem_addr_w-1:0] mem_addr,
    input  logic                           mem_we,
    input  logic [31:0]                    mem_wdata,
    output logic [31:0]                    mem_rdata,
    output dma_pkg::bus_m2s_t              bus_out,
    input  dma_pkg::bus_s2m_t              bus_in
);
    import dma_pkg::*;

    dma_cfg_t              cfg;
    logic                  start;
    logic                  dir;
    logic                  done;
    logic                  err;

    // Engine side of the buffer
    logic [mem_addr_w-1:0] eng_addr;
    logic                  eng_we;
    logic [31:0]           eng_wdata;
    logic [31:0]           eng_rdata;

    dma_regs i_regs (
        .clock     (clock),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_req   (cfg_req),
        .cfg_ready (cfg_ready),
        .cfg_rdata (cfg_rdata),
        .cfg       (cfg),
        .start     (start),
        .dir       (dir),
        .done      (done),
        .err       (err)
    );

    dma_buffer_mem i_buffer (
        .clock   (clock),
        .a_addr  (mem_addr),
        .a_we    (mem_we),
        .a_wdata (mem_wdata),
        .a_rdata (mem_rdata),
        .b_addr  (eng_addr),
        .b_we    (eng_we),
        .b_wdata (eng_wdata),
        .b_rdata (eng_rdata)
    );

    dma_transfer_engine i_engine (
        .clock     (clock),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .start     (start),
        .dir       (dir),
        .done      (done),
        .err       (err),
        .buf_addr  (eng_addr),
        .buf_we    (eng_we),
        .buf_wdata (eng_wdata),
        .buf_rdata (eng_rdata),
        .bus_out   (bus_out),
        .bus_in    (bus_in)
    );

endmodule

//--- source/dma_pkg.sv
/* Shared definitions for the DMA controller: sizes, register selects,
   configuration and bus structs, and the transfer engine states */

package dma_pkg;

    // Local buffer geometry
    localparam int mem_addr_w = 9;
    localparam int mem_depth  = 512;

    // Field widths of the transfer parameters
    localparam int block_w = 10;
    localparam int burst_w = 8;

    // Register select on the configuration port
    typedef enum logic [2:0] {
        sel_bus_start_addr = 3'd1,
        sel_mem_start_addr = 3'd2,
        sel_block_size     = 3'd3,
        sel_burst_size     = 3'd4,
        sel_ctrl_status    = 3'd5
    } cfg_sel_e;

    // One access on the configuration port
    typedef struct packed {
        cfg_sel_e    sel;
        logic        write;
        logic [31:0] data;
    } cfg_req_t;

    // Live transfer parameters, held in the register file
    typedef struct packed {
        logic [31:0]           bus_start_addr;
        logic [mem_addr_w-1:0] mem_start_addr;
        logic [block_w-1:0]    block_size;
        logic [burst_w-1:0]    burst_size;
    } dma_cfg_t;

    // Bus signals driven by the master
    typedef struct packed {
        logic               request;
        logic [31:0]        address_data;
        logic [burst_w-1:0] burst_size;
        logic               read_n_write;
        logic               begin_transaction;
        logic               end_transaction;
        logic               data_valid;
        logic               busy;
        logic               error;
    } bus_m2s_t;

    // Bus signals driven by the target
    typedef struct packed {
        logic        grant;
        logic [31:0] address_data;
        logic        end_transaction;
        logic        data_valid;
        logic        busy;
        logic        error;
    } bus_s2m_t;

    // Transfer engine FSM
    typedef enum logic [2:0] {
        st_idle,
        st_request,
        st_begin,
        st_read_data,
        st_write_data,
        st_end,
        st_next
    } engine_state_e;

endpackage

//--- source/dma_regs.sv
/* Configuration and status registers with valid/ready write port,
   start pulse generation and combinational read-back */

`timescale 1ns/1ps

module dma_regs (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              cfg_valid,
    input  dma_pkg::cfg_req_t cfg_req,
    output logic              cfg_ready,
    output logic [31:0]       cfg_rdata,
    output dma_pkg::dma_cfg_t cfg,
    output logic              start,
    output logic              dir,
    input  logic              done,
    input  logic              err
);
    import dma_pkg::*;

    // Bit 0 busy, bit 1 error
    logic [1:0] status;
    logic       cfg_write;
    logic       ctrl_write;

    // No writes accepted while a block is in flight
    assign cfg_ready = ~status[0];

    assign cfg_write  = cfg_valid && cfg_ready && cfg_req.write;
    assign ctrl_write = cfg_write && (cfg_req.sel == sel_ctrl_status);

    // Control bits are not stored and only fire the start pulse
    assign start = ctrl_write && (cfg_req.data[0] || cfg_req.data[1]);

    // Bit 0 (bus to buffer) has priority over bit 1 (buffer to bus)
    assign dir = ~cfg_req.data[0];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cfg    <= '0;
            status <= '0;
        end else begin
            if (cfg_write) begin
                case (cfg_req.sel)
                    sel_bus_start_addr: cfg.bus_start_addr <= cfg_req.data;
                    sel_mem_start_addr: cfg.mem_start_addr <= cfg_req.data[mem_addr_w-1:0];
                    sel_block_size:     cfg.block_size     <= cfg_req.data[block_w-1:0];
                    sel_burst_size:     cfg.burst_size     <= cfg_req.data[burst_w-1:0];
                    default: ;
                endcase
            end

            // New block sets busy and clears a stale error
            if (start) begin
                status <= 2'b01;
            end else begin
                if (done) begin
                    status[0] <= 1'b0;
                end
                if (err) begin
                    status[1] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        cfg_rdata = '0;
        case (cfg_req.sel)
            sel_bus_start_addr: cfg_rdata = cfg.bus_start_addr;
            sel_mem_start_addr: cfg_rdata[mem_addr_w-1:0] = cfg.mem_start_addr;
            sel_block_size:     cfg_rdata[block_w-1:0] = cfg.block_size;
            sel_burst_size:     cfg_rdata[burst_w-1:0] = cfg.burst_size;
            // Control bits read as 0 in [1:0] and status sits in [3:2]
            sel_ctrl_status:    cfg_rdata[3:2] = status;
            default: ;
        endcase
    end

endmodule

//--- source/dma_transfer_engine.sv
/* Bus master of the DMA: splits a block into bursts and moves words
   between the shared bus and the local buffer in either direction */

`timescale 1ns/1ps

module dma_transfer_engine (
    input  logic                           clock,
    input  logic                           rst_n,
    input  dma_pkg::dma_cfg_t              cfg,
    input  logic                           start,
    input  logic                           dir,
    output logic                           done,
    output logic                           err,
    output logic [dma_pkg::mem_addr_w-1:0] buf_addr,
    output logic                           buf_we,
    output logic [31:0]                    buf_wdata,
    input  logic [31:0]                    buf_rdata,
    output dma_pkg::bus_m2s_t              bus_out,
    input  dma_pkg::bus_s2m_t              bus_in
);
    import dma_pkg::*;

    engine_state_e state;

    // Direction latched on start (1 is buffer to bus) and the abort flag
    logic                  dir_q;
    logic                  aborted;

    // Running addresses and counters
    logic [31:0]           bus_addr;
    logic [mem_addr_w-1:0] buf_ptr;
    logic [mem_addr_w-1:0] fetch_ptr;
    logic [block_w-1:0]    words_left;
    logic [burst_w:0]      burst_words;
    logic [burst_w:0]      burst_left;
    logic [burst_w:0]      burst_len;
    logic [burst_w:0]      burst_len_m1;

    // Write side word staging
    logic [31:0]           hold_word;
    logic                  hold_valid;
    logic [31:0]           wr_word;

    logic                  in_xfer;
    logic                  rd_beat;
    logic                  wr_beat;

    // Last burst of a block is shorter
    assign burst_len = (words_left < block_w'(burst_words)) ? words_left[burst_w:0]
                                                            : burst_words;
    assign burst_len_m1 = burst_len - 1'b1;

    // Held word wins over the prefetched one after a busy cycle
    assign wr_word = hold_valid ? hold_word : buf_rdata;

    assign in_xfer = (state == st_begin) || (state == st_read_data) ||
                     (state == st_write_data) || (state == st_end);

    assign rd_beat = (state == st_read_data) && bus_in.data_valid && !bus_in.error;
    assign wr_beat = (state == st_write_data) && !bus_in.busy && !bus_in.error;

    // Fetch pointer runs one word ahead while writing to the bus
    assign buf_addr  = (state == st_write_data) ? fetch_ptr : buf_ptr;
    assign buf_we    = rd_beat;
    assign buf_wdata = bus_in.address_data;

    always_comb begin
        bus_out         = '0;
        bus_out.request = (state == st_request) || in_xfer;
        if (state == st_begin) begin
            bus_out.begin_transaction = 1'b1;
            bus_out.address_data      = bus_addr;
            bus_out.burst_size        = burst_len_m1[burst_w-1:0];
            bus_out.read_n_write      = ~dir_q;
        end
        if (state == st_write_data) begin
            bus_out.address_data = wr_word;
            bus_out.data_valid   = 1'b1;
        end
        if (state == st_end) begin
            bus_out.end_transaction = 1'b1;
        end
    end

    // FSM and handshake flags
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state      <= st_idle;
            done       <= 1'b0;
            err        <= 1'b0;
            aborted    <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            done <= 1'b0;
            err  <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        aborted <= 1'b0;
                        // Empty block finishes at once
                        if (cfg.block_size == '0) begin
                            done <= 1'b1;
                        end else begin
                            state <= st_request;
                        end
                    end
                end
                st_request: begin
                    if (bus_in.grant) begin
                        state <= st_begin;
                    end
                end
                st_begin: begin
                    hold_valid <= 1'b0;
                    state      <= dir_q ? st_write_data : st_read_data;
                end
                st_read_data: begin
                    // Target closes read bursts
                    if (bus_in.end_transaction) begin
                        state <= st_next;
                    end
                end
                st_write_data: begin
                    if (wr_beat) begin
                        hold_valid <= 1'b0;
                        if (burst_left == 1) begin
                            state <= st_end;
                        end
                    end else if (bus_in.busy && !hold_valid) begin
                        hold_valid <= 1'b1;
                    end
                end
                st_end: begin
                    state <= st_next;
                end
                st_next: begin
                    if (aborted || words_left == '0) begin
                        done  <= 1'b1;
                        state <= st_idle;
                    end else begin
                        state <= st_request;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase

            // Target error kills the rest of the block
            if (in_xfer && bus_in.error) begin
                err     <= 1'b1;
                aborted <= 1'b1;
                state   <= st_next;
            end
        end
    end

    // Addresses, counters and staged data
    always_ff @(posedge clock) begin
        if (state == st_idle && start) begin
            dir_q       <= dir;
            bus_addr    <= cfg.bus_start_addr;
            buf_ptr     <= cfg.mem_start_addr;
            words_left  <= cfg.block_size;
            burst_words <= {1'b0, cfg.burst_size} + 1'b1;
        end
        if (state == st_begin) begin
            burst_left <= burst_len;
            fetch_ptr  <= buf_ptr + 1'b1;
        end
        if (rd_beat || wr_beat) begin
            bus_addr   <= bus_addr + 32'd4;
            buf_ptr    <= buf_ptr + 1'b1;
            words_left <= words_left - 1'b1;
            burst_left <= burst_left - 1'b1;
        end
        if (wr_beat) begin
            fetch_ptr <= fetch_ptr + 1'b1;
        end
        // Capture the word on the bus before the buffer output moves on
        if (state == st_write_data && bus_in.busy && !hold_valid) begin
            hold_word <= buf_rdata;
        end
    end

endmodule
